// ==== design/hsk_pkg.sv ====
package hsk_pkg;

    // port id seen as a register file index
    typedef struct packed {
        logic       is_buffer;
        logic [1:0] pad;
        logic       is_misc;
        logic [3:0] index;
    } hsk_reg_view_t;

    // port id seen as a buffer address, bit 6 picks packet or housekeeping half
    typedef struct packed {
        logic       is_buffer;
        logic       is_hsk;
        logic [5:0] offset;
    } hsk_buf_view_t;

    typedef union packed {
        hsk_reg_view_t reg_view;
        hsk_buf_view_t buf_view;
    } hsk_port_u;

    // port map
    // 0x00-0x07 buffer alias (keeps k-port mapping simple)
    // 0x08-0x0B uart, 0x0C-0x0F i2c and temperature, 0x10 id, 0x11 general control
    localparam logic [7:0] UART_PORT    = 8'h08;
    localparam logic [7:0] CTLSTAT_PORT = 8'h0B;
    localparam logic [7:0] SCL_PORT     = 8'h0D;
    localparam logic [7:0] SDA_PORT     = 8'h0E;
    localparam logic [7:0] TEMP_PORT    = 8'h0E;
    localparam logic [7:0] OURID_PORT   = 8'h10;
    localparam logic [7:0] GENCTL_PORT  = 8'h11;

    // match masks, bits 6 and 5 are never decoded
    localparam logic [7:0] MASK_UARTTX = 8'h9E;
    localparam logic [7:0] MASK_UARTRX = 8'h9D;
    localparam logic [7:0] MASK_SCL    = 8'h9D;
    localparam logic [7:0] MASK_SDA    = 8'h9E;
    localparam logic [7:0] MASK_TEMP   = 8'h9F;
    localparam logic [7:0] MASK_OURID  = 8'h91;

    // line positions in out_port and in the i2c read value
    localparam int unsigned SCL_BIT = 1;
    localparam int unsigned SDA_BIT = 0;

    localparam int unsigned TX_FIFO_DEPTH = 64;
    localparam int unsigned TX_PTR_W      = 6;
    localparam int unsigned BUF_ADDR_W    = 8;

    localparam logic [2:0] ID_BASE = 3'b010;

endpackage

// ==== design/hsk_port_decode.sv ====
`timescale 1ns/10ps
module hsk_port_decode import hsk_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       processor_reset,
    input  logic [7:0] port_id_i,
    input  logic [7:0] out_port_i,
    input  logic       write_strobe_i,
    input  logic       k_write_strobe_i,
    input  logic       read_strobe_i,
    input  logic       bank_i,
    output hsk_port_u  buf_port_o,
    output logic       buf_we_o,
    output logic       buf_bit6_o,
    output logic       tx_push_o,
    output logic       rx_pop_o,
    output logic       temp_latch_o,
    output logic       scl_we_o,
    output logic       sda_we_o,
    output logic       link_reset_o,
    output logic       hsk_sel_o,
    output logic       hsk_enable_t_o,
    output logic       hsk_enable_o
);

    hsk_port_u kport_id;
    logic      any_write;
    logic      ctl_write;
    logic      gc_write;
    logic      win_a;
    logic      win_b;
    logic      hsk_sel;
    logic      link_reset;
    logic      packet_bit6;
    logic      hsk_bit6;

    // masked compare, port constant is masked too so don't-care bits never matter
    function automatic logic port_match(input logic [7:0] id, input logic [7:0] port,
                                        input logic [7:0] mask);
        return (id & mask) == (port & mask);
    endfunction

    // k-writes only carry 4 bits of port
    // low k-ports go to the buffer, high ones to the register file
    assign kport_id = k_write_strobe_i ? {~port_id_i[3], 3'b000, port_id_i[3:0]} : port_id_i;
    assign any_write = write_strobe_i | k_write_strobe_i;

    // write enables
    assign buf_we_o  = any_write & kport_id.buf_view.is_buffer;
    assign tx_push_o = any_write & port_match(kport_id, UART_PORT, MASK_UARTTX);
    assign ctl_write = any_write & port_match(kport_id, CTLSTAT_PORT, MASK_UARTTX);
    assign scl_we_o  = any_write & port_match(kport_id, SCL_PORT, MASK_SCL);
    assign sda_we_o  = any_write & port_match(kport_id, SDA_PORT, MASK_SDA);
    // general control has no k-port alias
    assign gc_write  = write_strobe_i & port_match(port_id_i, GENCTL_PORT, MASK_OURID);

    // read side effects, 0x08/0x0A pop rx and 0x0E grabs the temperature top bits
    assign rx_pop_o     = read_strobe_i & port_match(port_id_i, UART_PORT, MASK_UARTRX);
    assign temp_latch_o = read_strobe_i & port_match(port_id_i, TEMP_PORT, MASK_TEMP);

    // enable pins only driven for the cycle of the control write
    assign hsk_enable_t_o = ~gc_write;
    assign hsk_enable_o   = out_port_i[7];

    // buffer bit 6
    // packet half follows the window of the current bank
    // hsk half writes to the select and reads the other side
    assign packet_bit6 = bank_i ? win_b : win_a;
    assign hsk_bit6    = write_strobe_i ? hsk_sel : ~hsk_sel;
    assign buf_bit6_o  = kport_id.buf_view.is_hsk ? hsk_bit6 : packet_bit6;
    assign buf_port_o  = kport_id;

    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            win_a      <= 1'b0;
            win_b      <= 1'b0;
            hsk_sel    <= 1'b0;
            // link comes up held
            link_reset <= 1'b1;
        end else begin
            if (ctl_write) begin
                link_reset <= out_port_i[7];
                // each bank tracks its own window
                if (bank_i) begin
                    win_b <= out_port_i[1];
                end else begin
                    win_a <= out_port_i[1];
                end
            end
            if (gc_write) begin
                hsk_sel <= out_port_i[0];
            end
        end
    end

    assign link_reset_o = link_reset;
    assign hsk_sel_o    = hsk_sel;

endmodule

// ==== design/hsk_packet_ram.sv ====
`timescale 1ns/10ps
module hsk_packet_ram import hsk_pkg::*; (
    input  logic       wb_clk_i,
    input  hsk_port_u  buf_port_i,
    input  logic       buf_bit6_i,
    input  logic       we_i,
    input  logic [7:0] wdata_i,
    output logic [7:0] rdata_o
);

    // layout of the 256 bytes
    // 0x00-0x3F packet window 0
    // 0x40-0x7F packet window 1
    // 0x80-0xBF hsk half 0
    // 0xC0-0xFF hsk half 1
    localparam int unsigned RAM_DEPTH = 2 ** BUF_ADDR_W;

    logic [7:0]            mem [RAM_DEPTH];
    logic [BUF_ADDR_W-1:0] addr;
    logic [7:0]            rdata_q;

    // bit 7 of the port only says "buffer" so it drops out here
    // port bit 6 moves up to pick packet vs hsk region
    // and the decoded window/select fills the freed bit 6
    assign addr = {buf_port_i.buf_view.is_hsk,
                   buf_bit6_i,
                   buf_port_i.buf_view.offset};

    // write port
    always_ff @(posedge wb_clk_i) begin
        if (we_i) begin
            mem[addr] <= wdata_i;
        end
    end

    // read port runs every cycle whatever the port,
    // the read mux decides later whether the byte is wanted
    // read-first on a collision, old byte comes out
    always_ff @(posedge wb_clk_i) begin
        rdata_q <= mem[addr];
    end

    assign rdata_o = rdata_q;

endmodule

// ==== design/hsk_tx_fifo.sv ====
`timescale 1ns/10ps
module hsk_tx_fifo import hsk_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       processor_reset,
    input  logic       push_i,
    input  logic [7:0] din_i,
    output logic [7:0] tx_data_o,
    output logic       tx_valid_o,
    input  logic       tx_ready_i
);

    logic [7:0]          mem [TX_FIFO_DEPTH];
    logic [TX_PTR_W-1:0] wr_ptr;
    logic [TX_PTR_W-1:0] rd_ptr;
    logic [TX_PTR_W:0]   count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    // count tops out at exactly the depth, so the msb alone flags full
    assign full    = count[TX_PTR_W];
    assign do_push = push_i & ~full;
    assign do_pop  = tx_valid_o & tx_ready_i;

    // fall-through, head byte shows as soon as it is written
    assign tx_valid_o = (count != '0);
    assign tx_data_o  = mem[rd_ptr];

    always_ff @(posedge wb_clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // pointers wrap naturally at the depth
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/hsk_rx_port.sv ====
`timescale 1ns/10ps
module hsk_rx_port (
    input  logic       wb_clk_i,
    input  logic       processor_reset,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    input  logic       rx_last_i,
    input  logic       rx_error_i,
    output logic       rx_ready_o,
    input  logic       pop_i,
    output logic [7:0] rx_byte_o,
    output logic [7:0] status_o,
    output logic       interrupt_o
);

    logic       full;
    logic [7:0] held_byte;
    logic       held_last;
    logic       held_error;
    logic       last_flag;
    logic       error_flag;

    assign rx_ready_o  = ~full;
    // processor gets interrupted for as long as a byte waits
    assign interrupt_o = full;
    assign rx_byte_o   = held_byte;
    assign status_o    = {6'b000000, last_flag, error_flag};

    // byte and its tags
    always_ff @(posedge wb_clk_i) begin
        if (rx_valid_i && rx_ready_o) begin
            held_byte  <= rx_data_i;
            held_last  <= rx_last_i;
            held_error <= rx_error_i;
        end
    end

    // status only moves on pop, so it describes the byte just read
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            full       <= 1'b0;
            last_flag  <= 1'b0;
            error_flag <= 1'b0;
        end else if (rx_valid_i && !full) begin
            full <= 1'b1;
        end else if (pop_i && full) begin
            full       <= 1'b0;
            last_flag  <= held_last;
            error_flag <= held_error;
        end
    end

endmodule

// ==== design/hsk_i2c_lines.sv ====
`timescale 1ns/10ps
module hsk_i2c_lines import hsk_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       processor_reset,
    input  logic       scl_we_i,
    input  logic       sda_we_i,
    input  logic [7:0] out_port_i,
    output logic       scl_oe_o,
    output logic       sda_oe_o
);

    // open drain, lines are only ever pulled low
    // out_port bit high means release, so the enable is its inverse
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            // let go of the bus while the processor is held
            scl_oe_o <= 1'b0;
            sda_oe_o <= 1'b0;
        end else begin
            if (scl_we_i) begin
                scl_oe_o <= ~out_port_i[SCL_BIT];
            end
            // 0x0F hits both lines at once
            if (sda_we_i) begin
                sda_oe_o <= ~out_port_i[SDA_BIT];
            end
        end
    end

endmodule

// ==== design/hsk_in_port_mux.sv ====
`timescale 1ns/10ps
module hsk_in_port_mux import hsk_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        processor_reset,
    input  hsk_port_u   port_id_i,
    input  logic [7:0]  buf_data_i,
    input  logic [7:0]  rx_byte_i,
    input  logic [7:0]  rx_status_i,
    input  logic        scl_i,
    input  logic        sda_i,
    input  logic [11:0] temp_i,
    input  logic        temp_latch_i,
    input  logic [1:0]  conf_i,
    input  logic        hsk_enable_i,
    input  logic        hsk_sel_i,
    output logic [7:0]  in_port_o
);

    logic [3:0] temp_high;
    logic [7:0] i2c_val;
    logic [7:0] our_id;
    logic [7:0] gen_ctl;
    logic [7:0] misc_val;
    logic [7:0] reg_val;
    logic [7:0] reg_q;
    logic       buf_sel;
    logic       buf_sel_q;

    // top nibble frozen at the low byte read so 14 then 15 is one sample
    always_ff @(posedge wb_clk_i) begin
        if (temp_latch_i) begin
            temp_high <= temp_i[11:8];
        end
    end

    always_comb begin
        i2c_val          = 8'h00;
        i2c_val[SCL_BIT] = scl_i;
        i2c_val[SDA_BIT] = sda_i;
    end

    // id is 0x40 + conf*8
    assign our_id   = {ID_BASE, conf_i, 3'b000};
    assign gen_ctl  = {hsk_enable_i, 6'b000000, hsk_sel_i};
    assign misc_val = (port_id_i.reg_view.index[0] == OURID_PORT[0]) ? our_id : gen_ctl;

    // 0-7 alias the buffer like bit 7 does
    always_comb begin
        buf_sel = 1'b0;
        reg_val = 8'h00;
        if (port_id_i.reg_view.is_buffer) begin
            buf_sel = 1'b1;
        end else if (port_id_i.reg_view.is_misc) begin
            reg_val = misc_val;
        end else begin
            case (port_id_i.reg_view.index)
                4'h8, 4'hA: reg_val = rx_byte_i;
                4'h9, 4'hB: reg_val = rx_status_i;
                4'hC, 4'hD: reg_val = i2c_val;
                4'hE:       reg_val = temp_i[7:0];
                4'hF:       reg_val = {4'h0, temp_high};
                default:    buf_sel = 1'b1;
            endcase
        end
    end

    // buffer byte is already registered inside the ram,
    // so only the choice is registered here and both line up on the same edge
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            reg_q     <= 8'h00;
            buf_sel_q <= 1'b0;
        end else begin
            reg_q     <= reg_val;
            buf_sel_q <= buf_sel;
        end
    end

    assign in_port_o = buf_sel_q ? buf_data_i : reg_q;

endmodule

// ==== design/hsk_top.sv ====
`timescale 1ns/10ps
module hsk_top import hsk_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        processor_reset,
    // processor port bus
    input  logic [7:0]  port_id_i,
    input  logic [7:0]  out_port_i,
    input  logic        write_strobe_i,
    input  logic        k_write_strobe_i,
    input  logic        read_strobe_i,
    input  logic        bank_i,
    output logic [7:0]  in_port_o,
    output logic        interrupt_o,
    // decoded serial receive stream
    input  logic [7:0]  rx_data_i,
    input  logic        rx_valid_i,
    input  logic        rx_last_i,
    input  logic        rx_error_i,
    output logic        rx_ready_o,
    // transmit stream toward the serializer
    output logic [7:0]  tx_data_o,
    output logic        tx_valid_o,
    input  logic        tx_ready_i,
    // board side
    input  logic [11:0] temp_i,
    input  logic [1:0]  conf_i,
    input  logic        hsk_enable_i,
    output logic        hsk_enable_t_o,
    output logic        hsk_enable_o,
    output logic        link_reset_o,
    input  logic        scl_i,
    input  logic        sda_i,
    output logic        scl_oe_o,
    output logic        sda_oe_o
);

    hsk_port_u  buf_port;
    logic       buf_we;
    logic       buf_bit6;
    logic       tx_push;
    logic       rx_pop;
    logic       temp_latch;
    logic       scl_we;
    logic       sda_we;
    logic       hsk_sel;
    logic [7:0] buf_data;
    logic [7:0] rx_byte;
    logic [7:0] rx_status;

    hsk_port_decode u_decode (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .port_id_i(port_id_i), .out_port_i(out_port_i),
        .write_strobe_i(write_strobe_i), .k_write_strobe_i(k_write_strobe_i),
        .read_strobe_i(read_strobe_i), .bank_i(bank_i),
        .buf_port_o(buf_port), .buf_we_o(buf_we), .buf_bit6_o(buf_bit6),
        .tx_push_o(tx_push), .rx_pop_o(rx_pop), .temp_latch_o(temp_latch),
        .scl_we_o(scl_we), .sda_we_o(sda_we), .link_reset_o(link_reset_o),
        .hsk_sel_o(hsk_sel), .hsk_enable_t_o(hsk_enable_t_o), .hsk_enable_o(hsk_enable_o)
    );

    hsk_packet_ram u_ram (
        .wb_clk_i(wb_clk_i), .buf_port_i(buf_port), .buf_bit6_i(buf_bit6),
        .we_i(buf_we), .wdata_i(out_port_i), .rdata_o(buf_data)
    );

    hsk_tx_fifo u_tx_fifo (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .push_i(tx_push), .din_i(out_port_i),
        .tx_data_o(tx_data_o), .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i)
    );

    hsk_rx_port u_rx_port (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .rx_data_i(rx_data_i), .rx_valid_i(rx_valid_i), .rx_last_i(rx_last_i),
        .rx_error_i(rx_error_i), .rx_ready_o(rx_ready_o), .pop_i(rx_pop),
        .rx_byte_o(rx_byte), .status_o(rx_status), .interrupt_o(interrupt_o)
    );

    hsk_i2c_lines u_i2c (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .scl_we_i(scl_we), .sda_we_i(sda_we), .out_port_i(out_port_i),
        .scl_oe_o(scl_oe_o), .sda_oe_o(sda_oe_o)
    );

    // reads use the raw port id, k-port mapping is write-only
    hsk_in_port_mux u_in_mux (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .port_id_i(port_id_i), .buf_data_i(buf_data), .rx_byte_i(rx_byte),
        .rx_status_i(rx_status), .scl_i(scl_i), .sda_i(sda_i),
        .temp_i(temp_i), .temp_latch_i(temp_latch), .conf_i(conf_i),
        .hsk_enable_i(hsk_enable_i), .hsk_sel_i(hsk_sel), .in_port_o(in_port_o)
    );

endmodule

// ==== dv/hsk_tb.sv ====
`timescale 1ns/10ps
module hsk_tb import hsk_pkg::*; ();

    // what a table step does on the port bus
    localparam logic [2:0] OP_IDLE = 3'd0;
    localparam logic [2:0] OP_WR   = 3'd1;
    localparam logic [2:0] OP_KWR  = 3'd2;
    localparam logic [2:0] OP_RD   = 3'd3;
    localparam logic [2:0] OP_BRD  = 3'd4;
    localparam logic [2:0] OP_TEMP = 3'd5;
    localparam logic [2:0] OP_RST  = 3'd6;

    // what a step checks
    // gc is looked at while the strobe is up, the rest after the edge that takes the step
    localparam logic [2:0] CK_NONE  = 3'd0;
    localparam logic [2:0] CK_IN    = 3'd1;
    localparam logic [2:0] CK_TX    = 3'd2;
    localparam logic [2:0] CK_FLAGS = 3'd3;
    localparam logic [2:0] CK_GC    = 3'd4;

    typedef struct packed {
        logic [3:0] test;
        logic [2:0] op;
        logic [7:0] port;
        logic [7:0] data;
        logic       bank;
        logic       rx_valid;
        logic       rx_last;
        logic       rx_error;
        logic [7:0] rx_data;
        logic       tx_ready;
        logic [2:0] ck;
        logic [7:0] exp;
    } step_t;

    logic        wb_clk_i;
    logic        processor_reset;
    logic [7:0]  port_id;
    logic [7:0]  out_port;
    logic        write_strobe;
    logic        k_write_strobe;
    logic        read_strobe;
    logic        bank;
    logic [7:0]  in_port;
    logic        interrupt;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_last;
    logic        rx_error;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic [11:0] temp;
    logic [1:0]  conf;
    logic        hsk_enable_in;
    logic        hsk_enable_t;
    logic        hsk_enable;
    logic        link_reset;
    logic        scl_in;
    logic        sda_in;
    logic        scl_oe;
    logic        sda_oe;

    step_t       steps[$];
    logic [7:0]  tx_exp[$];
    logic [3:0]  cur_test;
    logic [15:0] lfsr;
    int          cycles;
    int          cycle_limit;
    int          checks;
    int          errors;
    int          test_errs[1:6];
    string       test_names[1:6];

    initial begin
        wb_clk_i = 1'b0;
    end

    always #5 wb_clk_i = ~wb_clk_i;

    hsk_top UUT (
        .wb_clk_i(wb_clk_i), .processor_reset(processor_reset),
        .port_id_i(port_id), .out_port_i(out_port),
        .write_strobe_i(write_strobe), .k_write_strobe_i(k_write_strobe),
        .read_strobe_i(read_strobe), .bank_i(bank),
        .in_port_o(in_port), .interrupt_o(interrupt),
        .rx_data_i(rx_data), .rx_valid_i(rx_valid), .rx_last_i(rx_last),
        .rx_error_i(rx_error), .rx_ready_o(rx_ready),
        .tx_data_o(tx_data), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
        .temp_i(temp), .conf_i(conf), .hsk_enable_i(hsk_enable_in),
        .hsk_enable_t_o(hsk_enable_t), .hsk_enable_o(hsk_enable),
        .link_reset_o(link_reset), .scl_i(scl_in), .sda_i(sda_in),
        .scl_oe_o(scl_oe), .sda_oe_o(sda_oe)
    );

    // watchdog, limit is set once the table is built
    always @(posedge wb_clk_i) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing the table", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // galois lfsr, taps for x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic next_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            b[k] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic make_step(input logic [2:0] op, input logic [7:0] port,
                             input logic [7:0] data, input logic bnk,
                             input logic rxv, input logic rxl, input logic rxe,
                             input logic [7:0] rxd, input logic txr,
                             input logic [2:0] ck, input logic [7:0] exp);
        step_t s;
        s          = '0;
        s.test     = cur_test;
        s.op       = op;
        s.port     = port;
        s.data     = data;
        s.bank     = bnk;
        s.rx_valid = rxv;
        s.rx_last  = rxl;
        s.rx_error = rxe;
        s.rx_data  = rxd;
        s.tx_ready = txr;
        s.ck       = ck;
        s.exp      = exp;
        steps.push_back(s);
    endtask

    task automatic write_port(input logic [7:0] port, input logic [7:0] data,
                              input logic bnk, input logic [2:0] ck, input logic [7:0] exp);
        make_step(OP_WR, port, data, bnk, 0, 0, 0, 8'h00, 0, ck, exp);
    endtask

    task automatic kwrite_port(input logic [7:0] port, input logic [7:0] data, input logic bnk);
        make_step(OP_KWR, port, data, bnk, 0, 0, 0, 8'h00, 0, CK_NONE, 8'h00);
    endtask

    task automatic read_port(input logic [7:0] port, input logic bnk, input logic [7:0] exp);
        make_step(OP_RD, port, 8'h00, bnk, 0, 0, 0, 8'h00, 0, CK_IN, exp);
    endtask

    task automatic idle_step(input logic [2:0] ck, input logic [7:0] exp);
        make_step(OP_IDLE, 8'h00, 8'h00, 0, 0, 0, 0, 8'h00, 0, ck, exp);
    endtask

    // board pins packed as {3'b0, conf, hsk_enable, scl, sda}
    task automatic set_board(input logic [7:0] pins);
        make_step(OP_BRD, 8'h00, pins, 0, 0, 0, 0, 8'h00, 0, CK_NONE, 8'h00);
    endtask

    task automatic set_temp(input logic [11:0] t);
        make_step(OP_TEMP, {4'h0, t[11:8]}, t[7:0], 0, 0, 0, 0, 8'h00, 0, CK_NONE, 8'h00);
    endtask

    task automatic reset_step(input logic [2:0] ck, input logic [7:0] exp);
        make_step(OP_RST, 8'h00, 8'h00, 0, 0, 0, 0, 8'h00, 0, ck, exp);
    endtask

    task automatic recv_byte(input logic [7:0] d, input logic last, input logic err,
                             input logic [2:0] ck, input logic [7:0] exp);
        make_step(OP_IDLE, 8'h00, 8'h00, 0, 1, last, err, d, 0, ck, exp);
    endtask

    task automatic pop_tx(input logic [2:0] ck, input logic [7:0] exp);
        make_step(OP_IDLE, 8'h00, 8'h00, 0, 0, 0, 0, 8'h00, 1, ck, exp);
    endtask

    // flags byte for CK_FLAGS
    // {2'b0, interrupt, rx_ready, tx_valid, link_reset, scl_oe, sda_oe}
    task automatic build_table();
        logic [7:0] d0;
        logic [7:0] d1;
        logic [7:0] d2;
        logic [7:0] b;
        cur_test = 1;
        reset_step(CK_IN, 8'h00);
        reset_step(CK_FLAGS, 8'h14);
        // conf 10, hsk enable in high, both lines high
        set_board(8'h17);
        read_port(OURID_PORT, 0, 8'h50);
        set_board(8'h0F);
        read_port(OURID_PORT, 0, 8'h48);
        // gc check is {hsk_enable_t, hsk_enable}
        write_port(GENCTL_PORT, 8'h81, 0, CK_GC, 8'h01);
        idle_step(CK_GC, 8'h02);
        read_port(GENCTL_PORT, 0, 8'h81);
        write_port(GENCTL_PORT, 8'h00, 0, CK_GC, 8'h00);
        read_port(GENCTL_PORT, 0, 8'h80);

        cur_test = 2;
        next_byte(d0);
        next_byte(d1);
        next_byte(d2);
        // window a on, window b off
        write_port(CTLSTAT_PORT, 8'h02, 0, CK_NONE, 8'h00);
        write_port(CTLSTAT_PORT, 8'h00, 1, CK_NONE, 8'h00);
        // same port lands at 0x45 for bank 0 and 0x05 for bank 1
        write_port(8'h85, d0, 0, CK_NONE, 8'h00);
        write_port(8'h85, d1, 1, CK_NONE, 8'h00);
        read_port(8'h85, 0, d0);
        read_port(8'h85, 1, d1);
        // swap both windows over
        write_port(CTLSTAT_PORT, 8'h02, 1, CK_NONE, 8'h00);
        read_port(8'h85, 1, d0);
        write_port(CTLSTAT_PORT, 8'h00, 0, CK_NONE, 8'h00);
        read_port(8'h85, 0, d1);
        // k-port 3 maps to 0x83, offset 3 of the packet region
        kwrite_port(8'h03, d2, 0);
        read_port(8'h83, 0, d2);
        read_port(8'h03, 0, d2);

        cur_test = 3;
        next_byte(d0);
        next_byte(d1);
        // select 0 puts this one in hsk half 0
        write_port(8'hC5, d0, 0, CK_NONE, 8'h00);
        write_port(GENCTL_PORT, 8'h01, 0, CK_GC, 8'h00);
        write_port(8'hC5, d1, 0, CK_NONE, 8'h00);
        // reads see the other half
        read_port(8'hC5, 0, d0);
        write_port(GENCTL_PORT, 8'h00, 0, CK_GC, 8'h00);
        read_port(8'hC5, 0, d1);

        cur_test = 4;
        idle_step(CK_FLAGS, 8'h10);
        recv_byte(8'hA5, 1, 0, CK_FLAGS, 8'h20);
        idle_step(CK_FLAGS, 8'h20);
        read_port(UART_PORT, 0, 8'hA5);
        read_port(8'h09, 0, 8'h02);
        idle_step(CK_FLAGS, 8'h10);
        recv_byte(8'h3C, 0, 1, CK_NONE, 8'h00);
        read_port(8'h0A, 0, 8'h3C);
        read_port(CTLSTAT_PORT, 0, 8'h01);

        cur_test = 5;
        idle_step(CK_FLAGS, 8'h10);
        // two past the depth, the last two must vanish
        for (int k = 0; k < TX_FIFO_DEPTH + 2; k++) begin
            next_byte(b);
            if (k < TX_FIFO_DEPTH) begin
                tx_exp.push_back(b);
            end
            if (k == 2) begin
                kwrite_port(8'h09, b, 0);
            end else if (k == 0) begin
                write_port(UART_PORT, b, 0, CK_TX, b);
            end else begin
                write_port((k % 2 == 1) ? 8'h09 : UART_PORT, b, 0, CK_NONE, 8'h00);
            end
        end
        // head still waits with ready low
        idle_step(CK_TX, tx_exp[0]);
        for (int j = 0; j < TX_FIFO_DEPTH; j++) begin
            if (j == TX_FIFO_DEPTH - 1) begin
                pop_tx(CK_FLAGS, 8'h10);
            end else begin
                pop_tx(CK_TX, tx_exp[j + 1]);
            end
            if (j == 0) begin
                idle_step(CK_TX, tx_exp[1]);
            end
        end

        cur_test = 6;
        // scl high, sda low
        set_board(8'h0E);
        read_port(8'h0C, 0, 8'h02);
        set_board(8'h0D);
        read_port(SCL_PORT, 0, 8'h01);
        write_port(SCL_PORT, 8'h00, 0, CK_FLAGS, 8'h12);
        write_port(SDA_PORT, 8'h00, 0, CK_FLAGS, 8'h13);
        write_port(CTLSTAT_PORT, 8'h80, 0, CK_FLAGS, 8'h17);
        set_temp(12'hA5C);
        read_port(TEMP_PORT, 0, 8'h5C);
        // new sample must not leak into the nibble
        set_temp(12'h3E7);
        read_port(8'h0F, 0, 8'h0A);
        reset_step(CK_FLAGS, 8'h14);
    endtask

    // inputs change right after the edge, DUT takes them on the next one
    task automatic apply_step(input step_t s);
        processor_reset <= (s.op == OP_RST);
        write_strobe    <= (s.op == OP_WR);
        k_write_strobe  <= (s.op == OP_KWR);
        read_strobe     <= (s.op == OP_RD);
        port_id         <= s.port;
        out_port        <= s.data;
        bank            <= s.bank;
        rx_valid        <= s.rx_valid;
        rx_last         <= s.rx_last;
        rx_error        <= s.rx_error;
        rx_data         <= s.rx_data;
        tx_ready        <= s.tx_ready;
        if (s.op == OP_BRD) begin
            conf          <= s.data[4:3];
            hsk_enable_in <= s.data[2];
            scl_in        <= s.data[1];
            sda_in        <= s.data[0];
        end
        if (s.op == OP_TEMP) begin
            temp <= {s.port[3:0], s.data};
        end
    endtask

    task automatic count_error(input logic [3:0] t);
        errors++;
        test_errs[t]++;
    endtask

    // pins that follow the strobe in the same cycle
    task automatic check_during(input int idx);
        step_t s;
        s = steps[idx];
        checks++;
        if ({hsk_enable_t, hsk_enable} !== s.exp[1:0]) begin
            $display("Mismatch {hsk_enable_t_o,hsk_enable_o}: expected 0x%h, got 0x%h at step %0d",
                     s.exp[1:0], {hsk_enable_t, hsk_enable}, idx);
            count_error(s.test);
        end
    endtask

    // results of the edge that took step idx
    task automatic check_after(input int idx);
        step_t      s;
        logic [7:0] flags;
        s     = steps[idx];
        flags = {2'b00, interrupt, rx_ready, tx_valid, link_reset, scl_oe, sda_oe};
        case (s.ck)
            CK_IN: begin
                checks++;
                if (in_port !== s.exp) begin
                    $display("Mismatch in_port_o: expected 0x%02h, got 0x%02h at step %0d",
                             s.exp, in_port, idx);
                    count_error(s.test);
                end
            end
            CK_TX: begin
                checks++;
                if (tx_valid !== 1'b1) begin
                    $display("tx_valid_o is low at step %0d while byte 0x%02h should wait",
                             idx, s.exp);
                    count_error(s.test);
                end else if (tx_data !== s.exp) begin
                    $display("Mismatch tx_data_o: expected 0x%02h, got 0x%02h at step %0d",
                             s.exp, tx_data, idx);
                    count_error(s.test);
                end
            end
            CK_FLAGS: begin
                checks++;
                if (flags !== s.exp) begin
                    $display("Mismatch status pins {interrupt_o,rx_ready_o,tx_valid_o,%s",
                             "link_reset_o,scl_oe_o,sda_oe_o}:");
                    $display("Mismatch status pins: expected 0x%02h, got 0x%02h at step %0d",
                             s.exp, flags, idx);
                    count_error(s.test);
                end
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        int n;
        test_names[1] = "reset, id and general control";
        test_names[2] = "packet buffer windows and k-port";
        test_names[3] = "housekeeping half select";
        test_names[4] = "receive holding register";
        test_names[5] = "transmit fifo order and overflow";
        test_names[6] = "i2c lines, temperature and link reset";
        for (int t = 1; t <= 6; t++) begin
            test_errs[t] = 0;
        end
        lfsr   = 16'd59040;
        cycles = 0;
        checks = 0;
        errors = 0;
        build_table();
        n           = steps.size();
        cycle_limit = n + 20;

        processor_reset = 1'b1;
        port_id         = 8'h00;
        out_port        = 8'h00;
        write_strobe    = 1'b0;
        k_write_strobe  = 1'b0;
        read_strobe     = 1'b0;
        bank            = 1'b0;
        rx_data         = 8'h00;
        rx_valid        = 1'b0;
        rx_last         = 1'b0;
        rx_error        = 1'b0;
        tx_ready        = 1'b0;
        temp            = 12'h000;
        conf            = 2'b00;
        hsk_enable_in   = 1'b0;
        scl_in          = 1'b1;
        sda_in          = 1'b1;

        // two edges with reset high here
        // the two reset steps at the head of the table hold it for two more
        repeat (2) @(posedge wb_clk_i);

        // one step per cycle, checks at the falling edge where everything has settled
        for (int i = 0; i <= n; i++) begin
            if (i < n) begin
                apply_step(steps[i]);
            end else begin
                apply_step('0);
            end
            @(negedge wb_clk_i);
            if (i < n && steps[i].ck == CK_GC) begin
                check_during(i);
            end
            if (i > 0) begin
                if (steps[i - 1].ck != CK_GC) begin
                    check_after(i - 1);
                end
                // a test ends where the next step belongs to another one
                if (i == n || steps[i].test != steps[i - 1].test) begin
                    $display("test %0d (%s): %s, %0d errors", steps[i - 1].test,
                             test_names[steps[i - 1].test],
                             (test_errs[steps[i - 1].test] == 0) ? "ok" : "ERRORS",
                             test_errs[steps[i - 1].test]);
                end
            end
            @(posedge wb_clk_i);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/hsk_pkg.sv
design/hsk_port_decode.sv
design/hsk_packet_ram.sv
design/hsk_tx_fifo.sv
design/hsk_rx_port.sv
design/hsk_i2c_lines.sv
design/hsk_in_port_mux.sv
design/hsk_top.sv
dv/hsk_tb.sv

// ==== Bender.yml ====
package:
  name: hsk_periph

sources:
  # package first, blocks next, top level last
  - design/hsk_pkg.sv
  - design/hsk_port_decode.sv
  - design/hsk_packet_ram.sv
  - design/hsk_tx_fifo.sv
  - design/hsk_rx_port.sv
  - design/hsk_i2c_lines.sv
  - design/hsk_in_port_mux.sv
  - design/hsk_top.sv
  - target: test
    files:
      - dv/hsk_tb.sv
